// File: Makefile
# Verilator build and run for the LED controller testbench

BIN  := obj_dir/Vtb_led_ctrl
SRCS := $(filter-out +%,$(shell cat src.f)) led_settings.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) src.f
	verilator --binary --timing -Wno-fatal --top-module tb_led_ctrl -f src.f

# status follows the pass line in the simulator output
run: $(BIN)
	./$(BIN) | awk '{ print } /^Simulation finished: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: led_ctrl_top.sv
////////////////////////////////////////////////////////////
// LED controller top level
// SPI receiver, frame dispenser and PWM generator
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module led_ctrl_top
    import led_pkg::*;
(
    input  logic clk,
    input  logic reset_sig,
    input  logic spi_sck,
    input  logic spi_mosi,
    input  logic spi_cs_n,
    output logic pwm_red,
    output logic pwm_green,
    output logic pwm_blue,
    output logic pwm_white
);

    // byte link, one strobe per received byte
    level_t rx_byte;
    logic   rx_valid;

    rgbw_frame_if frame_if ();

    spi_byte_receiver u_receiver (
        .clk       (clk),
        .reset_sig (reset_sig),
        .spi_sck   (spi_sck),
        .spi_mosi  (spi_mosi),
        .spi_cs_n  (spi_cs_n),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid)
    );

    rgbw_data_dispenser u_dispenser (
        .clk       (clk),
        .reset_sig (reset_sig),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .frame_bus (frame_if.source)
    );

    rgbw_pwm_gen u_pwm (
        .clk       (clk),
        .reset_sig (reset_sig),
        .frame_bus (frame_if.sink),
        .pwm_red   (pwm_red),
        .pwm_green (pwm_green),
        .pwm_blue  (pwm_blue),
        .pwm_white (pwm_white)
    );

endmodule

// File: led_pkg.sv
////////////////////////////////////////////////////////////
// LED controller package
// channel level, frame and mode types plus the color palette
////////////////////////////////////////////////////////////

`include "led_settings.svh"

package led_pkg;

    // one channel level or one frame field
    typedef logic [`LED_BYTE_W-1:0] level_t;

    // anything other than steady is treated as off
    typedef enum logic [`LED_BYTE_W-1:0] {
        MODE_OFF    = 0,
        MODE_STEADY = 1
    } led_mode_e;

    // field order follows the byte order on the wire
    typedef struct packed {
        level_t    intensity;
        level_t    color_idx;
        level_t    red;
        level_t    green;
        level_t    blue;
        level_t    white;
        led_mode_e mode;
    } rgbw_frame_t;

    typedef struct packed {
        level_t red;
        level_t green;
        level_t blue;
        level_t white;
    } rgbw_t;

    // entry 0 is never selected, index 0 means direct color
    localparam rgbw_t led_palette [0:7] = '{
        '{8'd0,   8'd0,   8'd0,   8'd0},
        '{8'd255, 8'd0,   8'd0,   8'd0},
        '{8'd0,   8'd255, 8'd0,   8'd0},
        '{8'd0,   8'd0,   8'd255, 8'd0},
        '{8'd0,   8'd0,   8'd0,   8'd255},
        '{8'd255, 8'd128, 8'd0,   8'd0},
        '{8'd0,   8'd255, 8'd255, 8'd0},
        '{8'd255, 8'd96,  8'd32,  8'd128}
    };

endpackage

// File: led_settings.svh
////////////////////////////////////////////////////////////
// LED controller settings
// widths and framing constants shared by the RGBW design
////////////////////////////////////////////////////////////

`ifndef LED_SETTINGS_SVH
`define LED_SETTINGS_SVH

// width of one SPI byte and of every frame field
`define LED_BYTE_W 8

// value that opens every frame on the serial link
`define LED_SYNC_BYTE 8'h55

// bytes per frame, sync byte included
// sync, intensity, color index, red, green, blue, white, mode
`define LED_FRAME_LEN 8

// PWM counter width
// one period lasts 2**LED_PWM_W clock cycles
`define LED_PWM_W 8

`endif

// File: rgbw_data_dispenser.sv
////////////////////////////////////////////////////////////
// RGBW data dispenser
// waits for the sync byte, collects the fields of one frame
// and publishes them together on the mode byte
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "led_settings.svh"

module rgbw_data_dispenser
    import led_pkg::*;
(
    input  logic            clk,
    input  logic            reset_sig,
    input  level_t          rx_byte,
    input  logic            rx_valid,
    rgbw_frame_if.source    frame_bus
);

    // one spare bit so an overrun would be visible
    localparam int CNT_W = $clog2(`LED_FRAME_LEN + 1);
    localparam logic [CNT_W-1:0] LAST_POS = CNT_W'(`LED_FRAME_LEN - 1);

    // byte positions after the sync byte
    localparam logic [CNT_W-1:0] POS_INTENSITY = CNT_W'(1);
    localparam logic [CNT_W-1:0] POS_COLOR_IDX = CNT_W'(2);
    localparam logic [CNT_W-1:0] POS_RED       = CNT_W'(3);
    localparam logic [CNT_W-1:0] POS_GREEN     = CNT_W'(4);
    localparam logic [CNT_W-1:0] POS_BLUE      = CNT_W'(5);
    localparam logic [CNT_W-1:0] POS_WHITE     = CNT_W'(6);

    level_t           byte_q;
    logic             valid_q;
    logic [CNT_W-1:0] byte_cnt;

    // staged fields, only copied out once the frame is complete
    level_t intensity_s;
    level_t color_idx_s;
    level_t red_s;
    level_t green_s;
    level_t blue_s;
    level_t white_s;

    // input stage
    always_ff @(posedge clk) begin
        byte_q <= rx_byte;
    end

    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= rx_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_q) begin
            case (byte_cnt)
                POS_INTENSITY: intensity_s <= byte_q;
                POS_COLOR_IDX: color_idx_s <= byte_q;
                POS_RED:       red_s       <= byte_q;
                POS_GREEN:     green_s     <= byte_q;
                POS_BLUE:      blue_s      <= byte_q;
                POS_WHITE:     white_s     <= byte_q;
                default:       ;
            endcase
        end
    end

    // position 0 hunts for sync, the last position publishes
    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            byte_cnt              <= '0;
            frame_bus.frame       <= '0;
            frame_bus.frame_valid <= 1'b0;
        end else begin
            frame_bus.frame_valid <= 1'b0;
            if (valid_q) begin
                if (byte_cnt == '0) begin
                    if (byte_q == `LED_SYNC_BYTE) begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end else if (byte_cnt == LAST_POS) begin
                    byte_cnt                        <= '0;
                    frame_bus.frame.intensity       <= intensity_s;
                    frame_bus.frame.color_idx       <= color_idx_s;
                    frame_bus.frame.red             <= red_s;
                    frame_bus.frame.green           <= green_s;
                    frame_bus.frame.blue            <= blue_s;
                    frame_bus.frame.white           <= white_s;
                    frame_bus.frame.mode            <= led_mode_e'(byte_q);
                    frame_bus.frame_valid           <= 1'b1;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    a_cnt_in_range: assert property (
        @(posedge clk) disable iff (!reset_sig)
        byte_cnt < CNT_W'(`LED_FRAME_LEN)
    );

endmodule

// File: rgbw_frame_if.sv
////////////////////////////////////////////////////////////
// RGBW frame interface
// carries a published frame and its one-cycle update strobe
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface rgbw_frame_if
    import led_pkg::*;
();

    // holds its value between updates
    rgbw_frame_t frame;

    // high for one cycle when frame takes a new value
    logic        frame_valid;

    modport source (
        output frame,
        output frame_valid
    );

    modport sink (
        input  frame,
        input  frame_valid
    );

endinterface

// File: rgbw_pwm_gen.sv
////////////////////////////////////////////////////////////
// RGBW PWM generator
// palette lookup, intensity scaling and four PWM outputs
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "led_settings.svh"

module rgbw_pwm_gen
    import led_pkg::*;
(
    input  logic          clk,
    input  logic          reset_sig,
    rgbw_frame_if.sink    frame_bus,
    output logic          pwm_red,
    output logic          pwm_green,
    output logic          pwm_blue,
    output logic          pwm_white
);

    localparam int PALETTE_SIZE = 8;

    logic [`LED_PWM_W-1:0] pwm_cnt;
    logic                  pwm_wrap;

    rgbw_t source_lvl;
    rgbw_t scaled_lvl;
    rgbw_t pending_duty;
    rgbw_t active_duty;

    // level * (intensity + 1) / 256, never above 255
    function automatic level_t scale_level(input level_t lvl, input level_t inten);
        logic [2*`LED_BYTE_W-1:0] prod;
        prod = (2*`LED_BYTE_W)'(lvl) * ((2*`LED_BYTE_W)'(inten) + 1'b1);
        return prod[2*`LED_BYTE_W-1:`LED_BYTE_W];
    endfunction

    // indices 1..7 pick a palette entry, everything else uses the frame colors
    always_comb begin
        if (frame_bus.frame.color_idx != '0 &&
            frame_bus.frame.color_idx < `LED_BYTE_W'(PALETTE_SIZE)) begin
            source_lvl = led_palette[frame_bus.frame.color_idx[2:0]];
        end else begin
            source_lvl.red   = frame_bus.frame.red;
            source_lvl.green = frame_bus.frame.green;
            source_lvl.blue  = frame_bus.frame.blue;
            source_lvl.white = frame_bus.frame.white;
        end
    end

    always_comb begin
        scaled_lvl.red   = scale_level(source_lvl.red,   frame_bus.frame.intensity);
        scaled_lvl.green = scale_level(source_lvl.green, frame_bus.frame.intensity);
        scaled_lvl.blue  = scale_level(source_lvl.blue,  frame_bus.frame.intensity);
        scaled_lvl.white = scale_level(source_lvl.white, frame_bus.frame.intensity);
    end

    assign pwm_wrap = &pwm_cnt;

    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    // new duties wait here until the period ends
    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            pending_duty <= '0;
            active_duty  <= '0;
        end else begin
            if (frame_bus.frame_valid) begin
                if (frame_bus.frame.mode == MODE_STEADY) begin
                    pending_duty <= scaled_lvl;
                end else begin
                    pending_duty <= '0;
                end
            end
            if (pwm_wrap) begin
                active_duty <= pending_duty;
            end
        end
    end

    // high for exactly duty cycles out of each period
    assign pwm_red   = pwm_cnt < active_duty.red;
    assign pwm_green = pwm_cnt < active_duty.green;
    assign pwm_blue  = pwm_cnt < active_duty.blue;
    assign pwm_white = pwm_cnt < active_duty.white;

    // outputs only switch on at the start of a period
    a_rise_at_wrap: assert property (
        @(posedge clk) disable iff (!reset_sig)
        ($rose(pwm_red) || $rose(pwm_green) || $rose(pwm_blue) || $rose(pwm_white))
            |-> pwm_cnt == '0
    );

endmodule

// File: spi_byte_receiver.sv
////////////////////////////////////////////////////////////
// SPI byte receiver
// mode 0 slave, MSB first, one strobe per completed byte
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "led_settings.svh"

module spi_byte_receiver
    import led_pkg::*;
(
    input  logic   clk,
    input  logic   reset_sig,
    input  logic   spi_sck,
    input  logic   spi_mosi,
    input  logic   spi_cs_n,
    output level_t rx_byte,
    output logic   rx_valid
);

    localparam int BIT_CNT_W = $clog2(`LED_BYTE_W);
    localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(`LED_BYTE_W - 1);

    // two-flop synchronizers, sck gets a third stage for edge detection
    logic [2:0] sck_sync;
    logic [1:0] mosi_sync;
    logic [1:0] cs_n_sync;

    logic                    sck_rise;
    logic [`LED_BYTE_W-2:0]  shift_reg;
    logic [BIT_CNT_W-1:0]    bit_cnt;

    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            sck_sync  <= '0;
            cs_n_sync <= '1;
        end else begin
            sck_sync  <= {sck_sync[1:0], spi_sck};
            cs_n_sync <= {cs_n_sync[0], spi_cs_n};
        end
    end

    // data line synchronizer
    always_ff @(posedge clk) begin
        mosi_sync <= {mosi_sync[0], spi_mosi};
    end

    assign sck_rise = sck_sync[1] & ~sck_sync[2];

    // bit counter and strobe
    // a deselect drops any partial byte
    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (cs_n_sync[1]) begin
                bit_cnt <= '0;
            end else if (sck_rise) begin
                if (bit_cnt == LAST_BIT) begin
                    bit_cnt  <= '0;
                    rx_valid <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!cs_n_sync[1] && sck_rise) begin
            shift_reg <= {shift_reg[`LED_BYTE_W-3:0], mosi_sync[1]};
            if (bit_cnt == LAST_BIT) begin
                rx_byte <= {shift_reg, mosi_sync[1]};
            end
        end
    end

    // sck must hold each level for at least three clk cycles
    a_min_half_period: assert property (
        @(posedge clk) disable iff (!reset_sig)
        (sck_sync[1] != sck_sync[2]) |->
            !$past(sck_sync[1] != sck_sync[2], 1) && !$past(sck_sync[1] != sck_sync[2], 2)
    );

endmodule

// File: src.f
+incdir+.
led_pkg.sv
rgbw_frame_if.sv
spi_byte_receiver.sv
rgbw_data_dispenser.sv
rgbw_pwm_gen.sv
led_ctrl_top.sv
tb_led_ctrl.sv

// File: tb_led_ctrl.sv
////////////////////////////////////////////////////////////
// LED controller testbench
// directed SPI frames with PWM duty measurement
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "led_settings.svh"

module tb_led_ctrl
    import led_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;
    localparam int HALF_SCK   = 4;
    localparam int PWM_PERIOD = 1 << `LED_PWM_W;
    localparam int SETTLE     = 600;
    // 8 frames of up to 10 bytes at 64 cycles, 9 measurements, doubled
    localparam int WATCHDOG_CYCLES =
        2 * (8 * (10 * 64 + 32) + 9 * (SETTLE + PWM_PERIOD) + 16);

    logic clk;
    logic reset_sig;
    logic spi_sck;
    logic spi_mosi;
    logic spi_cs_n;
    logic pwm_red;
    logic pwm_green;
    logic pwm_blue;
    logic pwm_white;

    integer     seed;
    int         error_count;
    int         tests_passed;
    int         tests_failed;
    logic [7:0] tx_q [$];
    int         pwm_count [0:3];
    int         exp_duty [0:3];
    int         rnd_color [0:3];
    string      pwm_name [0:3];

    led_ctrl_top uut (
        .clk       (clk),
        .reset_sig (reset_sig),
        .spi_sck   (spi_sck),
        .spi_mosi  (spi_mosi),
        .spi_cs_n  (spi_cs_n),
        .pwm_red   (pwm_red),
        .pwm_green (pwm_green),
        .pwm_blue  (pwm_blue),
        .pwm_white (pwm_white)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // every drive lands a short delay after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DLY;
    endtask

    // mode 0, MSB first, data changes while sck is low
    task automatic spi_send_bits(input logic [7:0] value, input int n_bits);
        int i;
        for (i = 7; i > 7 - n_bits; i--) begin
            spi_mosi = value[i];
            wait_cycles(HALF_SCK);
            spi_sck = 1'b1;
            wait_cycles(HALF_SCK);
            spi_sck = 1'b0;
        end
    endtask

    task automatic spi_send_byte(input logic [7:0] value);
        spi_send_bits(value, 8);
    endtask

    // sends and empties the byte queue inside one chip select
    task automatic send_frame();
        spi_cs_n = 1'b0;
        wait_cycles(HALF_SCK);
        while (tx_q.size() > 0) begin
            spi_send_byte(tx_q.pop_front());
        end
        wait_cycles(HALF_SCK);
        spi_cs_n = 1'b1;
        wait_cycles(2 * HALF_SCK);
    endtask

    function automatic int scaled_duty(input int lvl, input int inten, input int mode);
        if (mode != 1) begin
            return 0;
        end
        return (lvl * (inten + 1)) / 256;
    endfunction

    // expected duties for one frame, palette for indices 1 to 7
    task automatic set_expected(input int inten, input int idx, input int r, input int g,
                                input int b, input int w, input int mode);
        if (idx >= 1 && idx <= 7) begin
            r = led_palette[idx].red;
            g = led_palette[idx].green;
            b = led_palette[idx].blue;
            w = led_palette[idx].white;
        end
        exp_duty[0] = scaled_duty(r, inten, mode);
        exp_duty[1] = scaled_duty(g, inten, mode);
        exp_duty[2] = scaled_duty(b, inten, mode);
        exp_duty[3] = scaled_duty(w, inten, mode);
    endtask

    // high cycles over one full period equal the duty at any phase
    task automatic measure_pwm();
        wait_cycles(SETTLE);
        for (int i = 0; i < 4; i++) begin
            pwm_count[i] = 0;
        end
        repeat (PWM_PERIOD) begin
            pwm_count[0] += int'(pwm_red);
            pwm_count[1] += int'(pwm_green);
            pwm_count[2] += int'(pwm_blue);
            pwm_count[3] += int'(pwm_white);
            wait_cycles(1);
        end
    endtask

    task automatic check_counts();
        for (int i = 0; i < 4; i++) begin
            if (pwm_count[i] != exp_duty[i]) begin
                $display("[FAIL] %s expected 0x%0h got 0x%0h",
                         pwm_name[i], exp_duty[i], pwm_count[i]);
                error_count++;
            end
        end
    endtask

    task automatic apply_and_check(input int inten, input int idx, input int r, input int g,
                                   input int b, input int w, input int mode);
        tx_q.push_back(`LED_SYNC_BYTE);
        tx_q.push_back(8'(inten));
        tx_q.push_back(8'(idx));
        tx_q.push_back(8'(r));
        tx_q.push_back(8'(g));
        tx_q.push_back(8'(b));
        tx_q.push_back(8'(w));
        tx_q.push_back(8'(mode));
        set_expected(inten, idx, r, g, b, w, mode);
        send_frame();
        measure_pwm();
        check_counts();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, error_count - errors_before);
            tests_failed++;
        end
    endtask

    task automatic idle_after_reset();
        int start_errors;
        start_errors = error_count;
        set_expected(0, 0, 0, 0, 0, 0, 0);
        measure_pwm();
        check_counts();
        finish_test("idle", start_errors);
    endtask

    task automatic direct_colors();
        int start_errors;
        start_errors = error_count;
        for (int i = 0; i < 4; i++) begin
            rnd_color[i] = $random(seed) & 8'hFF;
        end
        apply_and_check(255, 0, rnd_color[0], rnd_color[1], rnd_color[2], rnd_color[3], 1);
        finish_test("direct", start_errors);
    endtask

    // same colors as the direct test, then switched off
    task automatic intensity_scaling();
        int start_errors;
        start_errors = error_count;
        apply_and_check(127, 0, rnd_color[0], rnd_color[1], rnd_color[2], rnd_color[3], 1);
        apply_and_check(127, 0, rnd_color[0], rnd_color[1], rnd_color[2], rnd_color[3], 0);
        finish_test("intensity", start_errors);
    endtask

    task automatic palette_colors();
        int start_errors;
        start_errors = error_count;
        apply_and_check(255, 5, 8'h3C, 8'hC3, 8'h5A, 8'hA5, 1);
        apply_and_check(255, 7, 8'h01, 8'h02, 8'h03, 8'h04, 1);
        finish_test("palette", start_errors);
    endtask

    task automatic sync_hunt();
        int start_errors;
        start_errors = error_count;
        tx_q.push_back(8'h12);
        tx_q.push_back(8'hAA);
        apply_and_check(200, 0, 8'h40, 8'h80, 8'hC0, 8'h20, 1);
        // no byte here matches sync, so the previous duties must hold
        tx_q = '{8'h54, 8'hFF, 8'h00, 8'h11, 8'h22, 8'h33, 8'h44, 8'h01};
        send_frame();
        measure_pwm();
        check_counts();
        finish_test("sync", start_errors);
    endtask

    task automatic partial_byte_abort();
        int start_errors;
        start_errors = error_count;
        spi_cs_n = 1'b0;
        wait_cycles(HALF_SCK);
        spi_send_bits(8'hA5, 4);
        spi_cs_n = 1'b1;
        wait_cycles(2 * HALF_SCK);
        apply_and_check(255, 0, 8'h11, 8'h22, 8'h33, 8'h44, 1);
        finish_test("abort", start_errors);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        reset_sig    = 1'b0;
        spi_sck      = 1'b0;
        spi_mosi     = 1'b0;
        spi_cs_n     = 1'b1;
        seed         = 98633;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        pwm_name     = '{"pwm_red", "pwm_green", "pwm_blue", "pwm_white"};
        wait_cycles(8);
        reset_sig = 1'b1;
        wait_cycles(2);
        idle_after_reset();
        direct_colors();
        intensity_scaling();
        palette_colors();
        sync_hunt();
        partial_byte_abort();
        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
